/* src/robCore_macros.svh */
`ifndef ROBCORE_MACROS_SVH
`define ROBCORE_MACROS_SVH

// reorder buffer depth, kept a power of two so indices wrap
`define NUM_ROB 8

// physical register file size
`define NUM_PR 32

// architectural registers visible to software
`define NUM_ARCH 16

`endif

/* src/renamePkg.sv */
`include "robCore_macros.svh"

package renamePkg;

  typedef logic [$clog2(`NUM_ARCH)-1:0] archTag;
  typedef logic [$clog2(`NUM_PR)-1:0]   physTag;

  // instruction as offered on the dispatch port
  typedef struct packed {
    archTag destArch;
    logic   hasDest;
    logic   isBranch;
    logic   halt;
  } dispatchInstr;

  // instruction after renaming, written into the buffer
  typedef struct packed {
    archTag destArch;
    logic   hasDest;
    logic   isBranch;
    logic   halt;
    physTag newTag;
    // previous mapping, freed at retire
    physTag oldTag;
  } renamedInstr;

endpackage

/* src/robPkg.sv */
`include "robCore_macros.svh"

package robPkg;

  typedef logic [$clog2(`NUM_ROB)-1:0] robIdx;

  // one buffer slot
  typedef struct packed {
    renamePkg::renamedInstr instr;
    logic                   valid;
    logic                   complete;
  } robEntry;

  // head entry as it leaves the buffer
  typedef struct packed {
    renamePkg::archTag destArch;
    logic              hasDest;
    renamePkg::physTag newTag;
    // returned to the free list
    renamePkg::physTag oldTag;
    logic              halt;
  } retireInfo;

endpackage

/* src/freeList.sv */
`timescale 1ns/1ns
`include "robCore_macros.svh"

module freeList (
  input  logic              clock,
  input  logic              reset,
  input  logic              pop,
  input  logic              push,
  input  renamePkg::physTag pushTag,
  input  logic              checkpoint,
  input  logic              rollback,
  output renamePkg::physTag freeTag,
  output logic              freeEmpty
);

  localparam int DEPTH = `NUM_PR - `NUM_ARCH;
  // one extra wrap bit so full and empty differ
  localparam int PTR_W = $clog2(DEPTH) + 1;

  renamePkg::physTag queue [DEPTH];

  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] savedRdPtr;
  logic [PTR_W-1:0] count;
  logic [PTR_W-1:0] rdNext;
  logic [PTR_W-1:0] wrNext;

  assign rdNext    = rdPtr + PTR_W'(pop);
  assign wrNext    = wrPtr + PTR_W'(push);
  assign freeTag   = queue[rdPtr[PTR_W-2:0]];
  assign freeEmpty = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      rdPtr      <= '0;
      wrPtr      <= PTR_W'(DEPTH);
      savedRdPtr <= '0;
      count      <= PTR_W'(DEPTH);
      // tags above the architectural range start out free
      for (int i = 0; i < DEPTH; i++) begin
        queue[i] <= renamePkg::physTag'(`NUM_ARCH + i);
      end
    end else begin
      if (push) begin
        queue[wrPtr[PTR_W-2:0]] <= pushTag;
      end
      wrPtr <= wrNext;
      if (rollback) begin
        // tags popped since the branch are still in the queue
        rdPtr <= savedRdPtr;
        count <= wrNext - savedRdPtr;
      end else begin
        rdPtr <= rdNext;
        count <= count + PTR_W'(push) - PTR_W'(pop);
      end
      // include the branch's own pop, if any
      if (checkpoint) begin
        savedRdPtr <= rdNext;
      end
    end
  end

endmodule

/* src/mapTable.sv */
`timescale 1ns/1ns
`include "robCore_macros.svh"

module mapTable (
  input  logic              clock,
  input  logic              reset,
  input  renamePkg::archTag lookupArch,
  input  logic              renameWrite,
  input  renamePkg::archTag renameArch,
  input  renamePkg::physTag renameTag,
  input  logic              checkpoint,
  input  logic              rollback,
  input  logic              retireValid,
  input  robPkg::retireInfo retireOut,
  output renamePkg::physTag oldTag
);

  renamePkg::physTag specMap [`NUM_ARCH];
  renamePkg::physTag specNext [`NUM_ARCH];
  renamePkg::physTag ckptMap [`NUM_ARCH];
  // committed state, source for a full recovery
  renamePkg::physTag archMap [`NUM_ARCH];

  assign oldTag = specMap[lookupArch];

  // speculative map with this cycle's rename applied
  always_comb begin
    specNext = specMap;
    if (renameWrite) begin
      specNext[renameArch] = renameTag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        specMap[i] <= renamePkg::physTag'(i);
        ckptMap[i] <= renamePkg::physTag'(i);
        archMap[i] <= renamePkg::physTag'(i);
      end
    end else begin
      if (rollback) begin
        specMap <= ckptMap;
      end else begin
        specMap <= specNext;
      end
      if (checkpoint) begin
        ckptMap <= specNext;
      end
      if (retireValid && retireOut.hasDest) begin
        archMap[retireOut.destArch] <= retireOut.newTag;
      end
    end
  end

endmodule

/* src/renameStage.sv */
`timescale 1ns/1ns

module renameStage (
  input  logic                   dispatchValid,
  input  renamePkg::dispatchInstr dispatchIn,
  input  renamePkg::physTag      freeTag,
  input  logic                   freeEmpty,
  input  renamePkg::physTag      oldTag,
  input  logic                   robFull,
  input  logic                   branchPending,
  input  logic                   resolveValid,
  output logic                   dispatchReady,
  output logic                   pop,
  output logic                   renameWrite,
  output renamePkg::archTag      lookupArch,
  output logic                   allocate,
  output logic                   checkpoint,
  output renamePkg::renamedInstr renamedOut
);

  logic accept;
  logic noTag;
  logic branchBlock;

  // a destination needs a tag from the free list
  assign noTag       = dispatchIn.hasDest && freeEmpty;
  // only one checkpoint exists
  assign branchBlock = dispatchIn.isBranch && branchPending;

  // hold off during resolution so rollback sees a quiet front end
  assign dispatchReady = !robFull && !noTag && !branchBlock && !resolveValid;
  assign accept        = dispatchValid && dispatchReady;

  assign lookupArch  = dispatchIn.destArch;
  assign pop         = accept && dispatchIn.hasDest;
  assign renameWrite = accept && dispatchIn.hasDest;
  assign allocate    = accept;
  assign checkpoint  = accept && dispatchIn.isBranch;

  always_comb begin
    renamedOut.destArch = dispatchIn.destArch;
    renamedOut.hasDest  = dispatchIn.hasDest;
    renamedOut.isBranch = dispatchIn.isBranch;
    renamedOut.halt     = dispatchIn.halt;
    renamedOut.newTag   = freeTag;
    renamedOut.oldTag   = oldTag;
  end

endmodule

/* src/reorderBuffer.sv */
`timescale 1ns/1ns
`include "robCore_macros.svh"

module reorderBuffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   allocate,
  input  renamePkg::renamedInstr renamedIn,
  input  logic                   completeValid,
  input  robPkg::robIdx          completeIdx,
  input  logic                   resolveValid,
  input  logic                   mispredict,
  output logic                   robFull,
  output logic                   branchPending,
  output robPkg::robIdx          tailIdx,
  output logic                   rollback,
  output logic                   retireValid,
  output robPkg::retireInfo      retireOut
);

  localparam int CNT_W = $clog2(`NUM_ROB) + 1;

  robPkg::robEntry entries [`NUM_ROB];

  robPkg::robIdx    head;
  robPkg::robIdx    tail;
  logic [CNT_W-1:0] count;
  robPkg::robIdx    branchIdx;
  // distance of the pending branch from the head
  robPkg::robIdx    branchPos;
  logic [`NUM_ROB-1:0] flushMask;

  assign robFull     = (count == CNT_W'(`NUM_ROB));
  assign tailIdx     = tail;
  assign branchPos   = branchIdx - head;
  assign rollback    = resolveValid && mispredict && branchPending;
  assign retireValid = entries[head].valid && entries[head].complete;

  always_comb begin
    retireOut.destArch = entries[head].instr.destArch;
    retireOut.hasDest  = entries[head].instr.hasDest;
    retireOut.newTag   = entries[head].instr.newTag;
    retireOut.oldTag   = entries[head].instr.oldTag;
    retireOut.halt     = entries[head].instr.halt;
  end

  // everything younger than the branch, counted from the head
  always_comb begin
    robPkg::robIdx rel;
    for (int i = 0; i < `NUM_ROB; i++) begin
      rel          = robPkg::robIdx'(i) - head;
      flushMask[i] = (rel > branchPos);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      branchPending <= 1'b0;
      branchIdx     <= '0;
      for (int i = 0; i < `NUM_ROB; i++) begin
        entries[i].valid    <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      if (allocate) begin
        entries[tail].instr    <= renamedIn;
        entries[tail].valid    <= 1'b1;
        // branches have nothing left to execute
        entries[tail].complete <= renamedIn.isBranch;
        tail                   <= tail + 1'b1;
      end

      // late completions for flushed slots are dropped
      if (completeValid && entries[completeIdx].valid) begin
        entries[completeIdx].complete <= 1'b1;
      end

      if (retireValid) begin
        entries[head].valid <= 1'b0;
        head                <= head + 1'b1;
      end

      if (rollback) begin
        for (int i = 0; i < `NUM_ROB; i++) begin
          if (flushMask[i]) begin
            entries[i].valid <= 1'b0;
          end
        end
        tail  <= branchIdx + 1'b1;
        count <= CNT_W'(branchPos) + CNT_W'(1) - CNT_W'(retireValid);
      end else begin
        count <= count + CNT_W'(allocate) - CNT_W'(retireValid);
      end

      // dispatch is held off while resolving, so these never overlap
      if (resolveValid) begin
        branchPending <= 1'b0;
      end else if (allocate && renamedIn.isBranch) begin
        branchPending <= 1'b1;
        branchIdx     <= tail;
      end
    end
  end

endmodule

/* src/robCore.sv */
`timescale 1ns/1ns

module robCore (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatchValid,
  input  renamePkg::dispatchInstr dispatchIn,
  input  logic                    completeValid,
  input  robPkg::robIdx           completeIdx,
  input  logic                    resolveValid,
  input  logic                    mispredict,
  output logic                    dispatchReady,
  output robPkg::robIdx           dispatchRobIdx,
  output logic                    retireValid,
  output robPkg::retireInfo       retireOut,
  output logic                    haltOut
);

  logic                   pop;
  logic                   freeEmpty;
  renamePkg::physTag      freeTag;
  renamePkg::physTag      oldTag;
  renamePkg::archTag      lookupArch;
  logic                   renameWrite;
  logic                   allocate;
  logic                   checkpoint;
  renamePkg::renamedInstr renamed;
  logic                   robFull;
  logic                   branchPending;
  logic                   rollback;

  assign haltOut = retireValid && retireOut.halt;

  freeList u_freeList (
    .clock      (clock),
    .reset      (reset),
    .pop        (pop),
    .push       (retireValid && retireOut.hasDest),
    .pushTag    (retireOut.oldTag),
    .checkpoint (checkpoint),
    .rollback   (rollback),
    .freeTag    (freeTag),
    .freeEmpty  (freeEmpty)
  );

  mapTable u_mapTable (
    .clock       (clock),
    .reset       (reset),
    .lookupArch  (lookupArch),
    .renameWrite (renameWrite),
    .renameArch  (renamed.destArch),
    .renameTag   (renamed.newTag),
    .checkpoint  (checkpoint),
    .rollback    (rollback),
    .retireValid (retireValid),
    .retireOut   (retireOut),
    .oldTag      (oldTag)
  );

  renameStage u_renameStage (
    .dispatchValid (dispatchValid),
    .dispatchIn    (dispatchIn),
    .freeTag       (freeTag),
    .freeEmpty     (freeEmpty),
    .oldTag        (oldTag),
    .robFull       (robFull),
    .branchPending (branchPending),
    .resolveValid  (resolveValid),
    .dispatchReady (dispatchReady),
    .pop           (pop),
    .renameWrite   (renameWrite),
    .lookupArch    (lookupArch),
    .allocate      (allocate),
    .checkpoint    (checkpoint),
    .renamedOut    (renamed)
  );

  reorderBuffer u_reorderBuffer (
    .clock         (clock),
    .reset         (reset),
    .allocate      (allocate),
    .renamedIn     (renamed),
    .completeValid (completeValid),
    .completeIdx   (completeIdx),
    .resolveValid  (resolveValid),
    .mispredict    (mispredict),
    .robFull       (robFull),
    .branchPending (branchPending),
    .tailIdx       (dispatchRobIdx),
    .rollback      (rollback),
    .retireValid   (retireValid),
    .retireOut     (retireOut)
  );

endmodule

/* verification/robCoreModel.svh */
`ifndef ROBCORE_MODEL_SVH
`define ROBCORE_MODEL_SVH

// one in-flight instruction, oldest first in robQ
typedef struct packed {
  robPkg::robIdx          idx;
  renamePkg::renamedInstr instr;
  logic                   complete;
} modelEntry;

modelEntry         robQ[$];
renamePkg::physTag freeQ[$];
// tags popped after the pending branch, in pop order
renamePkg::physTag sinceCkpt[$];
renamePkg::physTag specMap [`NUM_ARCH];
renamePkg::physTag ckptMap [`NUM_ARCH];
robPkg::robIdx     tailModel;
robPkg::robIdx     pendingIdx;
logic              branchOpen;

function void resetModel();
  robQ.delete();
  freeQ.delete();
  sinceCkpt.delete();
  for (int i = 0; i < `NUM_ARCH; i++) begin
    specMap[i] = renamePkg::physTag'(i);
    ckptMap[i] = renamePkg::physTag'(i);
  end
  // free tags start above the identity mapping, ascending
  for (int i = `NUM_ARCH; i < `NUM_PR; i++) begin
    freeQ.push_back(renamePkg::physTag'(i));
  end
  tailModel  = '0;
  pendingIdx = '0;
  branchOpen = 1'b0;
endfunction

function void dispatchModel(renamePkg::dispatchInstr d);
  modelEntry e;
  e.idx            = tailModel;
  e.instr.destArch = d.destArch;
  e.instr.hasDest  = d.hasDest;
  e.instr.isBranch = d.isBranch;
  e.instr.halt     = d.halt;
  e.instr.oldTag   = specMap[d.destArch];
  // only meaningful with a destination
  e.instr.newTag   = '0;
  e.complete       = d.isBranch;
  if (d.hasDest) begin
    e.instr.newTag = freeQ.pop_front();
    specMap[d.destArch] = e.instr.newTag;
    if (branchOpen) begin
      sinceCkpt.push_back(e.instr.newTag);
    end
  end
  // snapshot taken after the branch's own rename
  if (d.isBranch) begin
    ckptMap    = specMap;
    sinceCkpt.delete();
    branchOpen = 1'b1;
    pendingIdx = tailModel;
  end
  robQ.push_back(e);
  tailModel = tailModel + 1'b1;
endfunction

function void completeModel(robPkg::robIdx idx);
  modelEntry e;
  for (int i = 0; i < robQ.size(); i++) begin
    if (robQ[i].idx == idx) begin
      e          = robQ[i];
      e.complete = 1'b1;
      robQ[i]    = e;
    end
  end
endfunction

function void resolveModel(logic wrong);
  if (wrong) begin
    // youngest branch in the queue is the pending one
    while (!robQ[robQ.size() - 1].instr.isBranch) begin
      void'(robQ.pop_back());
    end
    tailModel = robQ[robQ.size() - 1].idx + 1'b1;
    specMap   = ckptMap;
    for (int i = sinceCkpt.size() - 1; i >= 0; i--) begin
      freeQ.push_front(sinceCkpt[i]);
    end
  end
  sinceCkpt.delete();
  branchOpen = 1'b0;
endfunction

function void retireModel();
  modelEntry e;
  e = robQ.pop_front();
  if (e.instr.hasDest) begin
    freeQ.push_back(e.instr.oldTag);
  end
endfunction

`endif

/* verification/robCoreTb.sv */
`timescale 1ns/1ns
`include "robCore_macros.svh"

module robCoreTb;

  logic                    clock;
  logic                    reset;
  logic                    dispatchValid;
  renamePkg::dispatchInstr dispatchIn;
  logic                    completeValid;
  robPkg::robIdx           completeIdx;
  logic                    resolveValid;
  logic                    mispredict;
  logic                    dispatchReady;
  robPkg::robIdx           dispatchRobIdx;
  logic                    retireValid;
  robPkg::retireInfo       retireOut;
  logic                    haltOut;

  int drainCycles;
  int mispredicts;
  int haltsRetired;
  int fullBlocks;
  int branchBlocks;

  `include "robCoreModel.svh"

  robCore u_robCore (
    .clock          (clock),
    .reset          (reset),
    .dispatchValid  (dispatchValid),
    .dispatchIn     (dispatchIn),
    .completeValid  (completeValid),
    .completeIdx    (completeIdx),
    .resolveValid   (resolveValid),
    .mispredict     (mispredict),
    .dispatchReady  (dispatchReady),
    .dispatchRobIdx (dispatchRobIdx),
    .retireValid    (retireValid),
    .retireOut      (retireOut),
    .haltOut        (haltOut)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      failRun($sformatf("error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic driveInputs(input bit allowDispatch, input int completeRate);
    renamePkg::dispatchInstr d;
    bit headBranch;
    d.destArch    = renamePkg::archTag'($urandom);
    d.hasDest     = ($urandom % 4) != 0;
    d.isBranch    = ($urandom % 8) == 0;
    d.halt        = ($urandom % 16) == 0;
    dispatchIn    = d;
    dispatchValid = allowDispatch && (($urandom % 8) != 0);
    completeValid = ($urandom % 16) < completeRate;
    completeIdx   = robPkg::robIdx'($urandom);
    // a branch at the head retires next edge, so resolve it now
    headBranch    = branchOpen && robQ.size() > 0 && robQ[0].idx == pendingIdx;
    resolveValid  = branchOpen && (headBranch || ($urandom % 6) == 0);
    mispredict    = ($urandom % 2) == 0;
  endtask

  // compare outputs before the edge, then advance the model across it
  task automatic checkAndAdvance();
    bit        expReady;
    bit        expRetire;
    bit        noneComplete;
    modelEntry head;
    expReady = robQ.size() < `NUM_ROB && !(dispatchIn.hasDest && freeQ.size() == 0) &&
               !(dispatchIn.isBranch && branchOpen) && !resolveValid;
    expRetire = 1'b0;
    head      = '0;
    if (robQ.size() > 0) begin
      head      = robQ[0];
      expRetire = head.complete;
    end
    noneComplete = 1'b1;
    for (int i = 0; i < robQ.size(); i++) begin
      if (robQ[i].complete) begin
        noneComplete = 1'b0;
      end
    end
    compareValue("dispatchReady", 32'(dispatchReady), 32'(expReady));
    compareValue("dispatchRobIdx", 32'(dispatchRobIdx), 32'(tailModel));
    compareValue("retireValid", 32'(retireValid), 32'(expRetire));
    compareValue("haltOut", 32'(haltOut), 32'(expRetire && head.instr.halt));
    if (expRetire) begin
      compareValue("retireOut.destArch", 32'(retireOut.destArch), 32'(head.instr.destArch));
      compareValue("retireOut.hasDest", 32'(retireOut.hasDest), 32'(head.instr.hasDest));
      if (head.instr.hasDest) begin
        compareValue("retireOut.newTag", 32'(retireOut.newTag), 32'(head.instr.newTag));
        compareValue("retireOut.oldTag", 32'(retireOut.oldTag), 32'(head.instr.oldTag));
      end
      if (head.instr.halt) begin
        haltsRetired++;
      end
    end
    if (robQ.size() == `NUM_ROB && noneComplete && !dispatchReady) begin
      fullBlocks++;
    end
    if (dispatchIn.isBranch && branchOpen && !resolveValid && robQ.size() < `NUM_ROB) begin
      branchBlocks++;
    end
    // completion, resolution, retire and dispatch in the order the edge applies them
    if (completeValid) begin
      completeModel(completeIdx);
    end
    if (resolveValid) begin
      if (mispredict) begin
        mispredicts++;
      end
      resolveModel(mispredict);
    end
    if (expRetire) begin
      retireModel();
    end
    if (dispatchValid && expReady) begin
      dispatchModel(dispatchIn);
    end
  endtask

  initial begin
    void'($urandom(14633));
    reset         = 1'b1;
    dispatchValid = 1'b0;
    dispatchIn    = '0;
    completeValid = 1'b0;
    completeIdx   = '0;
    resolveValid  = 1'b0;
    mispredict    = 1'b0;
    mispredicts   = 0;
    haltsRetired  = 0;
    fullBlocks    = 0;
    branchBlocks  = 0;
    resetModel();
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    compareValue("retireValid", 32'(retireValid), 32'(0));
    compareValue("haltOut", 32'(haltOut), 32'(0));
    compareValue("dispatchReady", 32'(dispatchReady), 32'(1));

    // completion rate alternates so the buffer both fills and drains
    for (int cyc = 0; cyc < 4000; cyc++) begin
      @(posedge clock);
      #1;
      driveInputs(1'b1, ((cyc / 256) % 2 == 0) ? 1 : 12);
      @(negedge clock);
      checkAndAdvance();
    end

    drainCycles = 0;
    while (robQ.size() > 0 || branchOpen) begin
      if (drainCycles == 2000) begin
        failRun("timeout: the reorder buffer did not drain after dispatch stopped");
      end
      @(posedge clock);
      #1;
      driveInputs(1'b0, 12);
      @(negedge clock);
      checkAndAdvance();
      drainCycles++;
    end

    if (mispredicts == 0 || haltsRetired == 0 || fullBlocks == 0 || branchBlocks == 0) begin
      failRun($sformatf({"the run never reached every case (mispredicts %0d, halts %0d, ",
                         "full blocks %0d, branch blocks %0d)"},
                        mispredicts, haltsRetired, fullBlocks, branchBlocks));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* robCore.f */
+incdir+src
+incdir+verification
src/renamePkg.sv
src/robPkg.sv
src/freeList.sv
src/mapTable.sv
src/renameStage.sv
src/reorderBuffer.sv
src/robCore.sv
verification/robCoreTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module robCoreTb -f robCore.f -o robCoreSim
simOut=$(./obj_dir/robCoreSim || true)
echo "$simOut"
echo "$simOut" | grep -q "PASS: all tests"
